//--- design/sap_macros.svh
//**************************************************************************
// SAP-1 sizing macros
// Data and address widths, RAM depth, host credits, T-states per instruction
//**************************************************************************

`ifndef SAP_MACROS_SVH
`define SAP_MACROS_SVH

`define SAP_DATA_W       8  // Bus and register width
`define SAP_ADDR_W       4  // RAM address width
`define SAP_RAM_DEPTH    16 // Words of program memory
`define SAP_PROG_CREDITS 1  // Credits the host owns after reset
`define SAP_T_STATES     6  // Machine cycles per instruction

`endif

//--- design/sap_pkg.sv
//**************************************************************************
// SAP-1 shared types
// Opcode, T-state and programmer state enums, control word structs
//**************************************************************************

`include "sap_macros.svh"

package sap_pkg;

  typedef enum logic [3:0] {
    OP_LDA = 4'h0,  // A <= mem[op]
    OP_ADD = 4'h1,  // A <= A + mem[op]
    OP_SUB = 4'h2,  // A <= A - mem[op]
    OP_OUT = 4'he,  // Out <= A
    OP_HLT = 4'hf   // Stop; others are NOPs
  } opcode_e;

  typedef enum logic [2:0] {
    T_IDLE, T1, T2, T3, T4, T5, T6, T_HALT
  } tstate_e;

  typedef enum logic [1:0] {
    P_IDLE, P_ADDR, P_DATA, P_WRITE
  } prog_state_e;

  typedef struct packed {
    logic pc_inc;         // PC + 1
    logic pc_en;          // PC onto bus
    logic mar_load;       // MAR from bus
    logic ram_en;         // RAM[MAR] onto bus
    logic ir_load;        // IR from bus
    logic ir_en;          // IR operand onto bus
    logic a_load;         // A from bus
    logic a_en;           // A onto bus
    logic sub;            // ALU subtracts
    logic alu_en;         // ALU result onto bus
    logic b_load;         // B from bus
    logic out_load;       // Output reg from bus
    logic prog_en;        // Programmer owns datapath
    logic prog_addr_sel;  // Load address onto bus
    logic prog_data_sel;  // Load byte onto bus
  } ctrl_t;

  typedef struct packed {
    logic                   mar_load;   // MAR from load address
    logic                   ram_write;  // Write bus into RAM[MAR]
    logic                   bus_sel;    // 1 data, 0 address on bus
    logic [`SAP_ADDR_W-1:0] addr;
    logic [`SAP_DATA_W-1:0] data;
  } prog_ctrl_t;

endpackage

//--- design/sap_programmer.sv
//**************************************************************************
// SAP-1 program loader
// Credited byte intake, address counter and RAM write sequencer
//**************************************************************************

`include "sap_macros.svh"

module sap_programmer import sap_pkg::*; (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   programming,
  input  logic                   prog_valid,
  input  logic [`SAP_DATA_W-1:0] prog_byte,
  output logic                   prog_credit,
  output prog_ctrl_t             prog
);

  prog_state_e            state;
  logic [`SAP_DATA_W-1:0] byte_buf;   // One-entry buffer
  logic [`SAP_ADDR_W-1:0] addr_cnt;   // Next RAM address
  logic                   take;       // Byte accepted this edge

  // New byte only when buffer free or being drained this cycle
  assign take = programming && prog_valid &&
                (state == P_IDLE || state == P_WRITE);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= P_IDLE;
    end else begin
      case (state)
        P_IDLE:  if (take) state <= P_ADDR;
        P_ADDR:  state <= P_DATA;                    // MAR loaded
        P_DATA:  state <= P_WRITE;                   // Byte on bus
        P_WRITE: state <= take ? P_ADDR : P_IDLE;    // Back-to-back ok
        default: state <= P_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      byte_buf <= prog_byte;  // Hold byte through the sequence
    end
  end

  // Every session starts at address 0
  always_ff @(posedge clk) begin
    if (!resetn || !programming) begin
      addr_cnt <= '0;
    end else if (state == P_WRITE) begin
      addr_cnt <= addr_cnt + 1'b1;  // Step after each write
    end
  end

  always_comb begin
    prog      = '0;
    prog.addr = addr_cnt;
    prog.data = byte_buf;
    case (state)
      P_ADDR: begin
        prog.mar_load = 1'b1;   // Address counter to MAR
      end
      P_DATA: begin
        prog.bus_sel = 1'b1;    // Byte onto bus
      end
      P_WRITE: begin
        prog.bus_sel   = 1'b1;  // Keep byte on bus
        prog.ram_write = 1'b1;  // Commit at next edge
      end
      default: ;
    endcase
  end

  assign prog_credit = (state == P_WRITE);  // One pulse per byte

endmodule

//--- design/sap_controller.sv
//**************************************************************************
// SAP-1 controller
// T-state ring counter, microcode decoder and halt state
//**************************************************************************

module sap_controller import sap_pkg::*; (
  input  logic    clk,
  input  logic    resetn,
  input  logic    programming,
  input  opcode_e opcode,
  output ctrl_t   ctrl,
  output logic    halted
);

  tstate_e state;
  tstate_e state_nxt;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= T_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Ring through T1..T6, parked in T_IDLE while loading
  always_comb begin
    state_nxt = state;
    if (programming) begin
      state_nxt = T_IDLE;
    end else begin
      case (state)
        T_IDLE: state_nxt = T1;   // Start fetch at PC 0
        T1:     state_nxt = T2;
        T2:     state_nxt = T3;
        T3:     state_nxt = T4;
        T4:     state_nxt = (opcode == OP_HLT) ? T_HALT : T5;
        T5:     state_nxt = T6;
        T6:     state_nxt = T1;   // Next instruction
        T_HALT: state_nxt = T_HALT;  // Only reset or load leaves
        default: state_nxt = T_IDLE;
      endcase
    end
  end

  // Microcode table
  always_comb begin
    ctrl = '0;
    if (!programming) begin
      case (state)
        T1: begin
          ctrl.pc_en    = 1'b1;  // PC to MAR
          ctrl.mar_load = 1'b1;
        end
        T2: begin
          ctrl.pc_inc = 1'b1;
        end
        T3: begin
          ctrl.ram_en  = 1'b1;   // Instruction to IR
          ctrl.ir_load = 1'b1;
        end
        T4: begin
          case (opcode)
            OP_LDA, OP_ADD, OP_SUB: begin
              ctrl.ir_en    = 1'b1;  // Operand to MAR
              ctrl.mar_load = 1'b1;
            end
            OP_OUT: begin
              ctrl.a_en     = 1'b1;  // A to output reg
              ctrl.out_load = 1'b1;
            end
            default: ;               // HLT and NOPs idle here
          endcase
        end
        T5: begin
          case (opcode)
            OP_LDA: begin
              ctrl.ram_en = 1'b1;    // Memory to A
              ctrl.a_load = 1'b1;
            end
            OP_ADD, OP_SUB: begin
              ctrl.ram_en = 1'b1;    // Memory to B
              ctrl.b_load = 1'b1;
            end
            default: ;
          endcase
        end
        T6: begin
          if (opcode == OP_ADD || opcode == OP_SUB) begin
            ctrl.alu_en = 1'b1;      // Sum or difference to A
            ctrl.a_load = 1'b1;
            ctrl.sub    = (opcode == OP_SUB);
          end
        end
        default: ;                   // T_IDLE, T_HALT
      endcase
    end
  end

  assign halted = (state == T_HALT);

endmodule

//--- design/sap_datapath.sv
//**************************************************************************
// SAP-1 datapath
// PC, MAR, 16x8 RAM, IR, A, B, adder/subtractor, output register and the
// multiplexed bus with programmer override
//**************************************************************************

`include "sap_macros.svh"

module sap_datapath import sap_pkg::*; (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   programming,
  input  ctrl_t                  ctrl,
  input  prog_ctrl_t             prog,
  output opcode_e                opcode,
  output logic [`SAP_DATA_W-1:0] out_value,
  output logic                   out_valid
);

  localparam int DW = `SAP_DATA_W;
  localparam int AW = `SAP_ADDR_W;

  ctrl_t          cw;                      // Effective control word
  logic [DW-1:0]  bus;
  logic [DW-1:0]  alu;
  logic [AW-1:0]  pc;
  logic [AW-1:0]  mar;
  logic [DW-1:0]  ram [`SAP_RAM_DEPTH];
  logic [DW-1:0]  ir;
  logic [DW-1:0]  a_reg;
  logic [DW-1:0]  b_reg;
  logic [DW-1:0]  out_reg;
  logic           out_valid_q;

  // Loader owns the datapath while programming
  always_comb begin
    if (programming) begin
      cw               = '0;
      cw.prog_en       = 1'b1;
      cw.mar_load      = prog.mar_load;
      cw.prog_addr_sel = ~prog.bus_sel;
      cw.prog_data_sel = prog.bus_sel;
    end else begin
      cw = ctrl;
    end
  end

  assign alu = cw.sub ? (a_reg - b_reg) : (a_reg + b_reg);  // Wraps mod 256

  // Bus source mux, at most one enable expected
  always_comb begin
    bus = '0;
    if (cw.prog_data_sel) begin
      bus = prog.data;
    end else if (cw.prog_addr_sel) begin
      bus = {{(DW-AW){1'b0}}, prog.addr};
    end else if (cw.pc_en) begin
      bus = {{(DW-AW){1'b0}}, pc};
    end else if (cw.ram_en) begin
      bus = ram[mar];
    end else if (cw.ir_en) begin
      bus = {{(DW-AW){1'b0}}, ir[AW-1:0]};   // Operand field
    end else if (cw.a_en) begin
      bus = a_reg;
    end else if (cw.alu_en) begin
      bus = alu;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn || programming) begin
      pc <= '0;                       // Run restarts at 0
    end else if (cw.pc_inc) begin
      pc <= pc + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (cw.mar_load) begin
      mar <= bus[AW-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (cw.prog_en && prog.ram_write) begin
      ram[mar] <= bus;                // Loader write only
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ir <= '0;
    end else if (cw.ir_load) begin
      ir <= bus;
    end
  end

  always_ff @(posedge clk) begin
    if (cw.a_load) begin
      a_reg <= bus;
    end
    if (cw.b_load) begin
      b_reg <= bus;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      out_reg     <= '0;
      out_valid_q <= 1'b0;
    end else begin
      out_valid_q <= cw.out_load;     // Flag follows the load edge
      if (cw.out_load) begin
        out_reg <= bus;
      end
    end
  end

  assign opcode    = opcode_e'(ir[DW-1 -: $bits(opcode_e)]);
  assign out_value = out_reg;
  assign out_valid = out_valid_q && !programming;  // Quiet during load

endmodule

//--- design/sap_top.sv
//**************************************************************************
// SAP-1 top level
// Program loader, microcoded controller and datapath
//**************************************************************************

`include "sap_macros.svh"

module sap_top import sap_pkg::*; (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   programming,
  input  logic                   prog_valid,
  input  logic [`SAP_DATA_W-1:0] prog_byte,
  output logic                   prog_credit,
  output logic [`SAP_DATA_W-1:0] out_value,
  output logic                   out_valid,
  output logic                   halted
);

  ctrl_t      ctrl;    // Controller to datapath
  prog_ctrl_t prog;    // Loader to datapath
  opcode_e    opcode;  // IR high nibble back to controller

  sap_programmer i_programmer (
    .clk         (clk),
    .resetn      (resetn),
    .programming (programming),
    .prog_valid  (prog_valid),
    .prog_byte   (prog_byte),
    .prog_credit (prog_credit),
    .prog        (prog)
  );

  sap_controller i_controller (
    .clk         (clk),
    .resetn      (resetn),
    .programming (programming),
    .opcode      (opcode),
    .ctrl        (ctrl),
    .halted      (halted)
  );

  sap_datapath i_datapath (
    .clk         (clk),
    .resetn      (resetn),
    .programming (programming),
    .ctrl        (ctrl),
    .prog        (prog),
    .opcode      (opcode),
    .out_value   (out_value),
    .out_valid   (out_valid)
  );

endmodule

//--- tb/sap_sva.sv
//**************************************************************************
// SAP-1 protocol assertions
// Credit bound and latency, control word, halt hold, output quiet on load
//**************************************************************************

`include "sap_macros.svh"

module sap_sva import sap_pkg::*; (
  input logic  clk,
  input logic  resetn,
  input logic  programming,
  input logic  prog_valid,
  input logic  prog_credit,
  input logic  out_valid,
  input logic  halted,
  input ctrl_t ctrl
);
  timeunit 1ns;
  timeprecision 100ps;

  int cnt;  // Host credits as seen on the pins

  always_ff @(posedge clk) begin
    if (!resetn) begin
      cnt <= `SAP_PROG_CREDITS;
    end else begin
      cnt <= cnt + int'(prog_credit) - int'(prog_valid && programming);
    end
  end

  a_credit_bound: assert property (@(posedge clk) disable iff (!resetn)
    prog_credit |-> cnt < `SAP_PROG_CREDITS) else $error("credit overflow");

  a_credit_lat: assert property (@(posedge clk) disable iff (!resetn)
    prog_valid && programming |-> ##3 prog_credit) else $error("credit late");

  a_halt_hold: assert property (@(posedge clk) disable iff (!resetn)
    halted && !programming |=> halted) else $error("halt lost");

  a_out_quiet: assert property (@(posedge clk) disable iff (!resetn)
    programming |-> !out_valid) else $error("output during load");

  // Single bus driver
  a_bus_one: assert property (@(posedge clk) disable iff (!resetn)
    $onehot0({ctrl.pc_en, ctrl.ram_en, ctrl.ir_en, ctrl.a_en, ctrl.alu_en}))
    else $error("bus contention");

endmodule

//--- tb/sap_tb.sv
//**************************************************************************
// SAP-1 testbench
// Clock, reset, credit tracker, reference model, check task, watchdog and
// directed tests for load, arithmetic, halt, NOP and reprogramming
//**************************************************************************

`include "sap_macros.svh"

module sap_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic                   clk;
  logic                   resetn;
  logic                   programming;
  logic                   prog_valid;
  logic [`SAP_DATA_W-1:0] prog_byte;
  logic                   prog_credit;
  logic [`SAP_DATA_W-1:0] out_value;
  logic                   out_valid;
  logic                   halted;

  int                     seed = 32'haa40;
  int                     credits;       // Credits owned by the host
  int                     budget;        // Watchdog limit in cycles
  int                     cycle_cnt;
  int                     out_cnt;       // DUT outputs seen in the last run
  logic [7:0]             prog_q[$];     // Bytes of the next program
  logic [7:0]             mem_model [16]; // RAM as the host loaded it
  logic [7:0]             model_a;       // A persists across runs
  logic [7:0]             exp_q[$];      // Expected out_value sequence

  sap_top i_dut (
    .clk         (clk),
    .resetn      (resetn),
    .programming (programming),
    .prog_valid  (prog_valid),
    .prog_byte   (prog_byte),
    .prog_credit (prog_credit),
    .out_value   (out_value),
    .out_valid   (out_valid),
    .halted      (halted)
  );

  bind sap_top sap_sva i_sva (
    .clk         (clk),
    .resetn      (resetn),
    .programming (programming),
    .prog_valid  (prog_valid),
    .prog_credit (prog_credit),
    .out_valid   (out_valid),
    .halted      (halted),
    .ctrl        (ctrl)
  );

  always #2 clk = ~clk;  // 4 ns period

  // Spend on accepted byte, regain on prog_credit
  always @(posedge clk) begin
    if (!resetn) begin
      credits <= `SAP_PROG_CREDITS;
    end else begin
      credits <= credits + int'(prog_credit) - int'(prog_valid && programming);
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > budget) begin
      $display("Watchdog timeout: no finish within %0d cycles", budget);
      $display("SIMULATION FAILED");
      $fatal(1, "Watchdog expired");
    end
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Error: %s expected 0x%0h, got 0x%0h", name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic abort(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped");
  endtask

  // Waits for a credit, sends one byte, measures credit latency
  task automatic send_byte(input logic [7:0] b);
    int n;
    while (credits == 0) @(posedge clk);
    prog_valid <= 1'b1;
    prog_byte  <= b;
    @(posedge clk);          // Byte accepted here
    prog_valid <= 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!prog_credit);
    check("prog_credit latency", 3, n);
  endtask

  // Executes mem_model from address 0 until HLT
  task automatic model_run();
    logic [3:0] pc;
    logic [7:0] ir;
    int         steps;
    bit         done;
    pc    = '0;
    steps = 0;
    done  = 1'b0;
    exp_q.delete();
    while (!done && steps < 64) begin
      ir = mem_model[pc];
      pc = pc + 4'd1;        // Wraps at 16
      steps++;
      case (ir[7:4])
        4'h0: model_a = mem_model[ir[3:0]];
        4'h1: model_a = model_a + mem_model[ir[3:0]];
        4'h2: model_a = model_a - mem_model[ir[3:0]];
        4'he: exp_q.push_back(model_a);
        4'hf: done = 1'b1;
        default: ;           // NOP
      endcase
    end
    budget += `SAP_T_STATES * steps + 40;
  endtask

  // Loads prog_q from address 0, runs it, checks outputs and the halt
  task automatic load_and_run();
    @(posedge clk);
    programming <= 1'b1;
    foreach (prog_q[i]) begin
      mem_model[i] = prog_q[i];
      budget += 40;
      send_byte(prog_q[i]);
    end
    programming <= 1'b0;     // Last byte already written
    model_run();
    out_cnt = 0;
    do begin
      @(posedge clk);
      if (out_valid) begin
        if (out_cnt >= exp_q.size()) begin
          abort("DUT produced more outputs than the program has OUT steps");
        end else begin
          check("out_value", exp_q[out_cnt], out_value);
          out_cnt++;
        end
      end
    end while (!halted);
    repeat (12) begin        // Nothing may follow the halt
      @(posedge clk);
      check("out_valid", 0, out_valid);
      check("halted", 1, halted);
    end
    check("out_count", exp_q.size(), out_cnt);
  endtask

  task automatic fill_to(input int last);
    for (int i = prog_q.size(); i <= last; i++) begin
      prog_q.push_back(8'h50 | 8'(i));  // NOP filler tied to address
    end
  endtask

  task automatic test_load_output();
    prog_q = '{8'h0e, 8'he0, 8'hf0};   // LDA 14, OUT, HLT
    fill_to(13);
    prog_q.push_back(8'($random(seed)));
    load_and_run();
    check("lda out_count", 1, out_cnt);
  endtask

  task automatic test_credit_flow();
    budget += 20;
    @(posedge clk);
    prog_valid <= 1'b1;      // Sent while programming is low
    prog_byte  <= 8'ha5;
    @(posedge clk);
    prog_valid <= 1'b0;
    repeat (6) begin
      @(posedge clk);
      check("prog_credit", 0, prog_credit);
    end
    check("credits", `SAP_PROG_CREDITS, credits);
    check("halted", 1, halted);
  endtask

  task automatic test_arith();
    logic [7:0] r0;
    logic [7:0] r1;
    r0 = 8'($random(seed)) | 8'h80;    // Forces ADD wraparound
    r1 = 8'($random(seed)) | 8'h80;
    // LDA 12, ADD 13, OUT, SUB 14, OUT, ADD 15, OUT, HLT
    prog_q = '{8'h0c, 8'h1d, 8'he0, 8'h2e, 8'he0, 8'h1f, 8'he0, 8'hf0};
    fill_to(11);
    prog_q.push_back(r0);
    prog_q.push_back(r1);
    prog_q.push_back(8'(r0 + r1) + 8'd1);  // SUB wraps below zero
    prog_q.push_back(8'($random(seed)));
    load_and_run();
  endtask

  task automatic test_halt_nop();
    // LDA 15, NOP, OUT, NOP, OUT, HLT
    prog_q = '{8'h0f, 8'h70, 8'he0, 8'h3a, 8'he0, 8'hf0};
    fill_to(14);
    prog_q.push_back(8'($random(seed)));
    load_and_run();
    check("nop out_count", 2, out_cnt);
  endtask

  task automatic test_reprogram();
    @(posedge clk);
    programming <= 1'b1;
    @(posedge clk);
    @(posedge clk);
    check("halted", 0, halted);        // Cleared by the new load
    prog_q = '{8'h1f, 8'he0, 8'h2e, 8'he0};  // Falls into old OUT, HLT
    load_and_run();
  endtask

  initial begin
    clk         = 1'b0;
    resetn      = 1'b0;
    programming = 1'b1;      // Keep controller parked until RAM is loaded
    prog_valid  = 1'b0;
    prog_byte   = '0;
    cycle_cnt   = 0;
    budget      = 100;
    repeat (5) @(posedge clk);
    resetn <= 1'b1;
    test_load_output();
    test_credit_flow();
    test_arith();
    test_halt_nop();
    test_reprogram();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+design
design/sap_pkg.sv
design/sap_programmer.sv
design/sap_controller.sv
design/sap_datapath.sv
design/sap_top.sv
tb/sap_sva.sv
tb/sap_tb.sv

//--- Bender.yml
package:
  name: sap1

export_include_dirs:
  - design

sources:
  - design/sap_pkg.sv
  - design/sap_programmer.sv
  - design/sap_controller.sv
  - design/sap_datapath.sv
  - design/sap_top.sv
  - target: test
    files:
      - tb/sap_sva.sv
      - tb/sap_tb.sv
